//--- project.f
+incdir+common
common/uart_frame_pkg.sv
uart/uart_tx.sv
uart/uart_rx.sv
frame/frame_tx.sv
frame/frame_rx.sv
logic/uart_frame_top.sv
verif/tb_clock_gen.sv
verif/tb_uart_frame.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_uart_frame
FILELIST   := project.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := TESTBENCH PASSED
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -Wno-fatal -Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verif/tb_uart_frame.sv
// table-driven testbench for uart_frame_top, bit period 8 cycles
// loopback entries feed uart_txd back into uart_rxd
// injected entries drive raw serial bytes, bit 8 set means a low stop bit
`timescale 1ns/1ps
`default_nettype none

`include "uart_frame_macros.svh"

module tb_uart_frame;
	import uart_frame_pkg::*;

	localparam int CLKS_PER_BIT = 8;
	localparam int N_ENTRIES    = 9;
	localparam int RAW_DEPTH    = 64;
	localparam int HOLD_CYCLES  = 6;
	localparam int PW           = `UF_MAX_LEN * 8;

	typedef logic [PW-1:0] word_t;

	logic     sys_clk;
	logic     sys_rst_n;
	payload_t tx_payload;
	len_t     tx_length;
	logic     tx_req;
	logic     tx_ack;
	payload_t rx_payload;
	len_t     rx_length;
	logic     rx_req;
	logic     rx_ack;
	logic     uart_rxd;
	logic     uart_txd;
	logic     loop_en;
	logic     drv_rxd;

	// stimulus table
	bit         ent_loop [N_ENTRIES];
	bit         ent_expect [N_ENTRIES];
	int         ent_len [N_ENTRIES];
	payload_t   ent_payload [N_ENTRIES];
	int         ent_raw_start [N_ENTRIES];
	int         ent_raw_count [N_ENTRIES];
	logic [8:0] raw_mem [RAW_DEPTH];
	int         n_ent = 0;
	int         n_raw = 0;

	int unsigned cycle_count   = 0;
	int unsigned timeout_limit = 32'hffff_ffff;
	int          mon_count     = 0;
	int          rx_frames     = 0;
	logic        rx_req_seen   = 1'b0;

	tb_clock_gen u_clock_gen (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n)
	);

	uart_frame_top #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) dut (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.tx_payload (tx_payload),
		.tx_length  (tx_length),
		.tx_req     (tx_req),
		.tx_ack     (tx_ack),
		.rx_payload (rx_payload),
		.rx_length  (rx_length),
		.rx_req     (rx_req),
		.rx_ack     (rx_ack),
		.uart_rxd   (uart_rxd),
		.uart_txd   (uart_txd)
	);

	assign uart_rxd = loop_en ? uart_txd : drv_rxd;

	always @(posedge sys_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > timeout_limit) begin
			$display("Run stopped after %0d cycles, a handshake never completed", timeout_limit);
			$display("TESTBENCH FAILED");
			$fatal(1, "timeout");
		end
	end

	// count rising edges of rx_req
	always @(negedge sys_clk) begin
		if (rx_req === 1'b1 && rx_req_seen !== 1'b1) begin
			rx_frames <= rx_frames + 1;
		end
		rx_req_seen <= rx_req;
	end

	task automatic check_value(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("Error at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
			$display("TESTBENCH FAILED");
			$fatal(1, "check on %s failed", name);
		end
	endtask

	function automatic byte_t safe_random_byte();
		byte_t b;
		b = byte_t'($urandom);
		if (b == `UF_DELIM) begin
			b = b ^ 8'h40;
		end
		return b;
	endfunction

	task automatic add_loopback(input int len);
		payload_t p;
		p = '0;
		for (int i = 0; i < len; i++) begin
			p[8*i +: 8] = safe_random_byte();
		end
		ent_loop[n_ent]      = 1'b1;
		ent_expect[n_ent]    = 1'b1;
		ent_len[n_ent]       = len;
		ent_payload[n_ent]   = p;
		ent_raw_start[n_ent] = n_raw;
		ent_raw_count[n_ent] = 0;
		n_ent++;
	endtask

	task automatic add_injected(input bit expect_frame, input int len, input payload_t p);
		ent_loop[n_ent]      = 1'b0;
		ent_expect[n_ent]    = expect_frame;
		ent_len[n_ent]       = len;
		ent_payload[n_ent]   = p;
		ent_raw_start[n_ent] = n_raw;
		ent_raw_count[n_ent] = 0;
		n_ent++;
	endtask

	task automatic push_raw(input logic [8:0] b);
		raw_mem[n_raw] = b;
		n_raw++;
		ent_raw_count[n_ent-1]++;
	endtask

	task automatic build_table();
		logic [8:0] d;
		d = {1'b0, `UF_DELIM};
		add_loopback(0);
		add_loopback(1);
		add_loopback(5);
		add_loopback(`UF_MAX_LEN);
		// lone '&' then data
		add_injected(1'b0, 0, '0);
		push_raw(d);
		push_raw(9'h041);
		push_raw(9'h042);
		// non-'&' after the first closing '&'
		add_injected(1'b0, 0, '0);
		push_raw(d);
		push_raw(d);
		push_raw(9'h078);
		push_raw(d);
		push_raw(9'h079);
		// one payload byte too many
		add_injected(1'b0, 0, '0);
		push_raw(d);
		push_raw(d);
		for (int i = 0; i < `UF_MAX_LEN + 1; i++) begin
			push_raw(9'h061 + 9'(i));
		end
		// would close a frame that was not dropped, else opens one that 'z' breaks
		push_raw(d);
		push_raw(d);
		push_raw(d);
		push_raw(9'h07a);
		// the bad-stop '&' would have closed the frame early
		add_injected(1'b0, 0, '0);
		push_raw(d);
		push_raw(d);
		push_raw(9'h061);
		push_raw(9'h062);
		push_raw({1'b1, `UF_DELIM});
		push_raw(d);
		push_raw(9'h063);
		// good frame after the broken ones
		add_injected(1'b1, 3, payload_t'(24'h214b4f));
		push_raw(d);
		push_raw(d);
		push_raw(9'h04f);
		push_raw(9'h04b);
		push_raw(9'h021);
		push_raw(d);
		push_raw(d);
	endtask

	function automatic byte_t expected_line_byte(input int e, input int i);
		if (i < 2 || i >= ent_len[e] + 2) begin
			return `UF_DELIM;
		end
		return ent_payload[e][8*(i-2) +: 8];
	endfunction

	// caller is 1 ns past a rising edge
	task automatic drive_line(input logic v, input int cycles);
		drv_rxd = v;
		repeat (cycles) @(posedge sys_clk);
		#1;
	endtask

	task automatic send_serial_byte(input logic [8:0] b);
		drive_line(1'b0, CLKS_PER_BIT);
		for (int k = 0; k < 8; k++) begin
			drive_line(b[k], CLKS_PER_BIT);
		end
		if (b[8]) begin
			// low just past the receiver's mid-bit sample, then a long idle
			drive_line(1'b0, CLKS_PER_BIT / 2 + 1);
			drive_line(1'b1, 2 * CLKS_PER_BIT - CLKS_PER_BIT / 2 - 1);
		end else begin
			drive_line(1'b1, CLKS_PER_BIT);
		end
	endtask

	task automatic send_raw(input int e);
		@(posedge sys_clk);
		#1;
		for (int i = 0; i < ent_raw_count[e]; i++) begin
			send_serial_byte(raw_mem[ent_raw_start[e] + i]);
		end
	endtask

	task automatic read_serial_byte(output byte_t b, output logic stop);
		@(negedge sys_clk);
		while (uart_txd !== 1'b0) @(negedge sys_clk);
		repeat (CLKS_PER_BIT / 2) @(negedge sys_clk);
		check_value("uart_txd start bit", word_t'(uart_txd), word_t'(1'b0));
		for (int k = 0; k < 8; k++) begin
			repeat (CLKS_PER_BIT) @(negedge sys_clk);
			b[k] = uart_txd;
		end
		repeat (CLKS_PER_BIT) @(negedge sys_clk);
		stop = uart_txd;
	endtask

	task automatic monitor_frame(input int e);
		byte_t b;
		logic  stop;
		for (int i = 0; i < ent_len[e] + 4; i++) begin
			read_serial_byte(b, stop);
			check_value("uart_txd byte", word_t'(b), word_t'(expected_line_byte(e, i)));
			check_value("uart_txd stop bit", word_t'(stop), word_t'(1'b1));
			mon_count++;
		end
	endtask

	task automatic send_tx_frame(input int e);
		@(posedge sys_clk);
		#1;
		tx_payload = ent_payload[e];
		tx_length  = len_t'(ent_len[e]);
		tx_req     = 1'b1;
		@(negedge sys_clk);
		while (tx_ack !== 1'b1) @(negedge sys_clk);
		// whole frame must be out before the ack
		check_value("bytes seen at tx_ack", word_t'(mon_count), word_t'(ent_len[e] + 4));
		check_value("uart_txd at tx_ack", word_t'(uart_txd), word_t'(1'b1));
		repeat (2) begin
			@(negedge sys_clk);
			check_value("tx_ack while tx_req high", word_t'(tx_ack), word_t'(1'b1));
		end
		@(posedge sys_clk);
		#1;
		tx_req = 1'b0;
		@(negedge sys_clk);
		while (tx_ack !== 1'b0) @(negedge sys_clk);
	endtask

	task automatic receive_frame(input int e);
		@(negedge sys_clk);
		while (rx_req !== 1'b1) @(negedge sys_clk);
		check_value("rx_length", word_t'(rx_length), word_t'(ent_len[e]));
		check_value("rx_payload", word_t'(rx_payload), word_t'(ent_payload[e]));
		// ack held off, frame must stay put
		repeat (HOLD_CYCLES) begin
			@(negedge sys_clk);
			check_value("rx_req while rx_ack low", word_t'(rx_req), word_t'(1'b1));
			check_value("rx_length while held", word_t'(rx_length), word_t'(ent_len[e]));
			check_value("rx_payload while held", word_t'(rx_payload), word_t'(ent_payload[e]));
		end
		@(posedge sys_clk);
		#1;
		rx_ack = 1'b1;
		@(negedge sys_clk);
		while (rx_req !== 1'b0) @(negedge sys_clk);
		@(posedge sys_clk);
		#1;
		rx_ack = 1'b0;
	endtask

	task automatic run_entry(input int e);
		int frames_before;
		@(posedge sys_clk);
		#1;
		loop_en       = ent_loop[e];
		mon_count     = 0;
		frames_before = rx_frames;
		if (ent_loop[e]) begin
			fork
				send_tx_frame(e);
				monitor_frame(e);
				receive_frame(e);
			join
		end else if (ent_expect[e]) begin
			fork
				send_raw(e);
				receive_frame(e);
			join
		end else begin
			send_raw(e);
			// room for a late frame to show up
			repeat (3 * CLKS_PER_BIT) @(posedge sys_clk);
			#1;
		end
		check_value("frames received", word_t'(rx_frames - frames_before),
			word_t'(ent_expect[e]));
	endtask

	initial begin
		int n_bytes;
		int n_frames;
		tx_payload = '0;
		tx_length  = '0;
		tx_req     = 1'b0;
		rx_ack     = 1'b0;
		drv_rxd    = 1'b1;
		loop_en    = 1'b0;
		void'($urandom(32'h1487d150));
		build_table();
		n_bytes  = 0;
		n_frames = 0;
		for (int e = 0; e < n_ent; e++) begin
			n_bytes += ent_loop[e] ? ent_len[e] : ent_raw_count[e];
			if (ent_expect[e]) begin
				n_frames++;
			end
		end
		timeout_limit = (n_bytes + 4 * n_frames) * 10 * CLKS_PER_BIT * 2 + 2000;

		wait (sys_rst_n === 1'b1);
		repeat (4) begin
			@(negedge sys_clk);
			check_value("uart_txd after reset", word_t'(uart_txd), word_t'(1'b1));
			check_value("tx_ack after reset", word_t'(tx_ack), word_t'(1'b0));
			check_value("rx_req after reset", word_t'(rx_req), word_t'(1'b0));
		end

		for (int e = 0; e < n_ent; e++) begin
			run_entry(e);
		end

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- verif/tb_clock_gen.sv
// testbench clock and reset source
// 4 ns sys_clk, sys_rst_n low for the first 4 cycles
// reset leaves 1 ns after a rising edge
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic sys_clk,
	output logic sys_rst_n
);

	initial begin
		sys_clk = 1'b0;
		forever #2 sys_clk = ~sys_clk;
	end

	initial begin
		sys_rst_n = 1'b0;
		repeat (4) @(posedge sys_clk);
		#1;
		sys_rst_n = 1'b1;
	end

endmodule

`default_nettype wire

//--- logic/uart_frame_top.sv
// framed-string UART link, transmit and receive paths are independent
// both user sides use a four-phase req/ack handshake
// CLKS_PER_BIT must be 4 or more
`timescale 1ns/1ps
`default_nettype none

`include "uart_frame_macros.svh"

module uart_frame_top #(
	parameter int CLKS_PER_BIT = `UF_CLKS_PER_BIT
) (
	input  wire                           sys_clk,
	input  wire                           sys_rst_n,

	input  wire uart_frame_pkg::payload_t tx_payload,
	input  wire uart_frame_pkg::len_t     tx_length,
	input  wire                           tx_req,
	output wire                           tx_ack,

	output wire uart_frame_pkg::payload_t rx_payload,
	output wire uart_frame_pkg::len_t     rx_length,
	output wire                           rx_req,
	input  wire                           rx_ack,

	input  wire                           uart_rxd,
	output wire                           uart_txd
);
	import uart_frame_pkg::*;

	// frame_tx to uart_tx, four-phase
	wire byte_t tx_byte;
	wire        byte_req;
	wire        byte_ack;

	// uart_rx to frame_rx, single-cycle strobe
	wire byte_t rx_byte;
	wire        rx_byte_valid;

	frame_tx u_frame_tx (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.tx_payload (tx_payload),
		.tx_length  (tx_length),
		.tx_req     (tx_req),
		.tx_ack     (tx_ack),
		.byte_data  (tx_byte),
		.byte_req   (byte_req),
		.byte_ack   (byte_ack)
	);

	uart_tx #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) u_uart_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.byte_data (tx_byte),
		.byte_req  (byte_req),
		.byte_ack  (byte_ack),
		.txd       (uart_txd)
	);

	uart_rx #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) u_uart_rx (
		.sys_clk       (sys_clk),
		.sys_rst_n     (sys_rst_n),
		.rxd           (uart_rxd),
		.rx_byte       (rx_byte),
		.rx_byte_valid (rx_byte_valid)
	);

	frame_rx u_frame_rx (
		.sys_clk       (sys_clk),
		.sys_rst_n     (sys_rst_n),
		.rx_byte       (rx_byte),
		.rx_byte_valid (rx_byte_valid),
		.rx_payload    (rx_payload),
		.rx_length     (rx_length),
		.rx_req        (rx_req),
		.rx_ack        (rx_ack)
	);

endmodule

`default_nettype wire

//--- frame/frame_rx.sv
// parses '&' '&' payload '&' '&' out of the received byte stream
// holds one frame; bytes arriving during hand-off are dropped
// unused payload bytes read zero
`timescale 1ns/1ps
`default_nettype none

`include "uart_frame_macros.svh"

module frame_rx (
	input  wire                       sys_clk,
	input  wire                       sys_rst_n,
	input  wire uart_frame_pkg::byte_t rx_byte,
	input  wire                       rx_byte_valid,
	output uart_frame_pkg::payload_t  rx_payload,
	output uart_frame_pkg::len_t      rx_length,
	output logic                      rx_req,
	input  wire                       rx_ack
);
	import uart_frame_pkg::*;

	localparam int IDX_W = $clog2(`UF_MAX_LEN);

	typedef enum logic [2:0] {
		S_IDLE,
		S_OPEN,
		S_CONTENT,
		S_CLOSE,
		S_HANDOFF
	} state_t;

	state_t state_q;
	logic   is_delim;
	logic   full;
	logic   start;
	logic   store;

	assign is_delim = (rx_byte == `UF_DELIM);
	assign full     = (rx_length == len_t'(`UF_MAX_LEN));
	// second opening '&'
	assign start    = (state_q == S_OPEN) && rx_byte_valid && is_delim;
	assign store    = (state_q == S_CONTENT) && rx_byte_valid && !is_delim && !full;

	always_ff @(posedge sys_clk) begin
		if (start) begin
			rx_payload <= '0;
		end else if (store) begin
			rx_payload[8*rx_length[IDX_W-1:0] +: 8] <= rx_byte;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state_q   <= S_IDLE;
			rx_length <= '0;
			rx_req    <= 1'b0;
		end else begin
			case (state_q)
				S_IDLE: begin
					if (rx_byte_valid && is_delim) begin
						state_q <= S_OPEN;
					end
				end
				S_OPEN: begin
					if (rx_byte_valid) begin
						rx_length <= '0;
						state_q   <= is_delim ? S_CONTENT : S_IDLE;
					end
				end
				S_CONTENT: begin
					if (rx_byte_valid) begin
						if (is_delim) begin
							state_q <= S_CLOSE;
						end else if (full) begin
							// payload too long, drop the frame
							state_q <= S_IDLE;
						end else begin
							rx_length <= rx_length + 1'b1;
						end
					end
				end
				S_CLOSE: begin
					if (rx_byte_valid) begin
						if (is_delim) begin
							rx_req  <= 1'b1;
							state_q <= S_HANDOFF;
						end else begin
							state_q <= S_IDLE;
						end
					end
				end
				S_HANDOFF: begin
					if (rx_req && rx_ack) begin
						rx_req <= 1'b0;
					end else if (!rx_req && !rx_ack) begin
						state_q <= S_IDLE;
					end
				end
				default: state_q <= S_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- frame/frame_tx.sv
// sends a payload as '&' '&' payload '&' '&' over the byte link
// a length above UF_MAX_LEN is cut to UF_MAX_LEN
// payload bytes equal to '&' are sent unchanged
`timescale 1ns/1ps
`default_nettype none

`include "uart_frame_macros.svh"

module frame_tx (
	input  wire                       sys_clk,
	input  wire                       sys_rst_n,
	input  wire uart_frame_pkg::payload_t tx_payload,
	input  wire uart_frame_pkg::len_t tx_length,
	input  wire                       tx_req,
	output logic                      tx_ack,
	output uart_frame_pkg::byte_t     byte_data,
	output logic                      byte_req,
	input  wire                       byte_ack
);
	import uart_frame_pkg::*;

	localparam int IDX_W = $clog2(`UF_MAX_LEN);

	typedef enum logic [1:0] {S_IDLE, S_REQ, S_REL, S_ACK} state_t;

	state_t           state_q;
	payload_t         payload_q;
	len_t             len_q;
	// position in the frame, 0 up to len + 3
	logic [5:0]       pos_q;
	logic [IDX_W-1:0] data_idx;
	logic             in_payload;
	logic             last_byte;
	logic             accept;

	// wait for the last byte_ack to clear before a new frame
	assign accept     = (state_q == S_IDLE) && tx_req && !byte_ack;
	assign data_idx   = IDX_W'(pos_q - 6'd2);
	assign in_payload = (pos_q >= 6'd2) && (pos_q < {1'b0, len_q} + 6'd2);
	assign last_byte  = (pos_q == {1'b0, len_q} + 6'd3);
	assign byte_data  = in_payload ? payload_q[8*data_idx +: 8] : `UF_DELIM;

	always_ff @(posedge sys_clk) begin
		if (accept) begin
			payload_q <= tx_payload;
			if (tx_length > len_t'(`UF_MAX_LEN)) begin
				len_q <= len_t'(`UF_MAX_LEN);
			end else begin
				len_q <= tx_length;
			end
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state_q  <= S_IDLE;
			pos_q    <= '0;
			byte_req <= 1'b0;
			tx_ack   <= 1'b0;
		end else begin
			case (state_q)
				S_IDLE: begin
					if (accept) begin
						pos_q    <= '0;
						byte_req <= 1'b1;
						state_q  <= S_REQ;
					end
				end
				S_REQ: begin
					if (byte_ack) begin
						byte_req <= 1'b0;
						if (last_byte) begin
							// closing delimiter is on the line
							tx_ack  <= 1'b1;
							state_q <= S_ACK;
						end else begin
							state_q <= S_REL;
						end
					end
				end
				S_REL: begin
					if (!byte_ack) begin
						pos_q    <= pos_q + 6'd1;
						byte_req <= 1'b1;
						state_q  <= S_REQ;
					end
				end
				S_ACK: begin
					if (!tx_req) begin
						tx_ack  <= 1'b0;
						state_q <= S_IDLE;
					end
				end
				default: state_q <= S_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- uart/uart_rx.sv
// 8N1 deserializer with a two-flop input synchronizer
// CLKS_PER_BIT must be 4 or more
// rx_byte is valid only in the cycle of the rx_byte_valid pulse
// a byte whose stop bit reads low is dropped
`timescale 1ns/1ps
`default_nettype none

`include "uart_frame_macros.svh"

module uart_rx #(
	parameter int CLKS_PER_BIT = `UF_CLKS_PER_BIT
) (
	input  wire                    sys_clk,
	input  wire                    sys_rst_n,
	input  wire                    rxd,
	output uart_frame_pkg::byte_t  rx_byte,
	output logic                   rx_byte_valid
);
	import uart_frame_pkg::*;

	localparam int CNT_W = $clog2(CLKS_PER_BIT);
	localparam int HALF  = CLKS_PER_BIT / 2;

	typedef enum logic [1:0] {S_IDLE, S_START, S_DATA, S_STOP} state_t;

	state_t           state_q;
	logic             rxd_meta;
	logic             rxd_sync;
	logic [CNT_W-1:0] clk_cnt;
	logic [2:0]       bit_idx;
	byte_t            shift_q;
	logic             bit_end;
	logic             mid_start;

	assign bit_end   = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));
	assign mid_start = (clk_cnt == CNT_W'(HALF - 1));

	// line idles high
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
		end else begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state_q       <= S_IDLE;
			clk_cnt       <= '0;
			bit_idx       <= '0;
			rx_byte_valid <= 1'b0;
		end else begin
			rx_byte_valid <= 1'b0;
			case (state_q)
				S_IDLE: begin
					if (!rxd_sync) begin
						// this cycle already counts as part of the start bit
						clk_cnt <= CNT_W'(1);
						state_q <= S_START;
					end
				end
				S_START: begin
					if (mid_start) begin
						clk_cnt <= '0;
						bit_idx <= '0;
						// high again at mid-bit means a glitch
						state_q <= rxd_sync ? S_IDLE : S_DATA;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				S_DATA: begin
					if (bit_end) begin
						clk_cnt <= '0;
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == 3'd7) begin
							state_q <= S_STOP;
						end
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				S_STOP: begin
					if (bit_end) begin
						clk_cnt       <= '0;
						rx_byte_valid <= rxd_sync;
						state_q       <= S_IDLE;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				default: state_q <= S_IDLE;
			endcase
		end
	end

	// LSB arrives first, shift in from the top
	always_ff @(posedge sys_clk) begin
		if (state_q == S_DATA && bit_end) begin
			shift_q <= {rxd_sync, shift_q[7:1]};
		end
		if (state_q == S_STOP && bit_end && rxd_sync) begin
			rx_byte <= shift_q;
		end
	end

endmodule

`default_nettype wire

//--- uart/uart_tx.sv
// 8N1 serializer, one byte per four-phase req/ack exchange
// CLKS_PER_BIT must be 4 or more
// byte_data must stay stable while byte_req is high
`timescale 1ns/1ps
`default_nettype none

`include "uart_frame_macros.svh"

module uart_tx #(
	parameter int CLKS_PER_BIT = `UF_CLKS_PER_BIT
) (
	input  wire                   sys_clk,
	input  wire                   sys_rst_n,
	input  wire uart_frame_pkg::byte_t byte_data,
	input  wire                   byte_req,
	output logic                  byte_ack,
	output logic                  txd
);
	import uart_frame_pkg::*;

	localparam int CNT_W = $clog2(CLKS_PER_BIT);

	typedef enum logic [1:0] {S_IDLE, S_SEND, S_ACK} state_t;

	state_t           state_q;
	logic [CNT_W-1:0] clk_cnt;
	// 0 start, 1..8 data, 9 stop
	logic [3:0]       bit_idx;
	byte_t            shift_q;
	logic             bit_end;

	assign bit_end = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state_q  <= S_IDLE;
			clk_cnt  <= '0;
			bit_idx  <= '0;
			byte_ack <= 1'b0;
			txd      <= 1'b1;
		end else begin
			case (state_q)
				S_IDLE: begin
					if (byte_req) begin
						// start bit goes out right away
						txd     <= 1'b0;
						clk_cnt <= '0;
						bit_idx <= '0;
						state_q <= S_SEND;
					end
				end
				S_SEND: begin
					if (bit_end) begin
						clk_cnt <= '0;
						bit_idx <= bit_idx + 4'd1;
						if (bit_idx == 4'd9) begin
							// stop bit done
							byte_ack <= 1'b1;
							state_q  <= S_ACK;
						end else if (bit_idx == 4'd8) begin
							txd <= 1'b1;
						end else begin
							txd <= shift_q[0];
						end
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				S_ACK: begin
					// hold ack until the request drops
					if (!byte_req) begin
						byte_ack <= 1'b0;
						state_q  <= S_IDLE;
					end
				end
				default: state_q <= S_IDLE;
			endcase
		end
	end

	// data bits leave LSB first
	always_ff @(posedge sys_clk) begin
		if (state_q == S_IDLE && byte_req) begin
			shift_q <= byte_data;
		end else if (state_q == S_SEND && bit_end && bit_idx < 4'd8) begin
			shift_q <= {1'b0, shift_q[7:1]};
		end
	end

endmodule

`default_nettype wire

//--- common/uart_frame_pkg.sv
// data types of the framed UART link
// payload byte 0 sits in the lowest bits and goes out first
`default_nettype none

`include "uart_frame_macros.svh"

package uart_frame_pkg;

	// one serial character
	typedef logic [7:0] byte_t;

	// payload length, 0 up to UF_MAX_LEN
	typedef logic [$clog2(`UF_MAX_LEN + 1)-1:0] len_t;

	// whole payload, byte n at bits [8n+7:8n]
	typedef logic [`UF_MAX_LEN*8-1:0] payload_t;

endpackage

`default_nettype wire

//--- common/uart_frame_macros.svh
// constants shared by the framed UART link
// a payload may not contain the delimiter, nothing escapes it
`ifndef UART_FRAME_MACROS_SVH
`define UART_FRAME_MACROS_SVH

// frame delimiter, ASCII '&'
`define UF_DELIM 8'h26

// largest payload in bytes
`define UF_MAX_LEN 16

// 115200 baud from a 250 MHz sys_clk
`define UF_CLKS_PER_BIT 2170

`endif
